// ==== project.f ====
common/sha256_pkg.sv
sha256/round_constants.sv
sha256/message_schedule.sv
sha256/compress_core.sv
logic/axil_regs.sv
logic/sha256_axil_top.sv
tb/tb_sha256.sv

// ==== Bender.yml ====
package:
  name: sha256_axil

sources:
  - common/sha256_pkg.sv
  - sha256/round_constants.sv
  - sha256/message_schedule.sv
  - sha256/compress_core.sv
  - logic/axil_regs.sv
  - logic/sha256_axil_top.sv
  - target: test
    files:
      - tb/tb_sha256.sv

// ==== tb/tb_sha256.sv ====
`default_nettype none

module tb_sha256
	import sha256_pkg::*;
();

	localparam int NUM_TESTS = 27;
	localparam logic [1:0] OKAY   = 2'b00;
	localparam logic [1:0] SLVERR = 2'b10;

	localparam logic [255:0] IV = {
		32'h6a09e667, 32'hbb67ae85, 32'h3c6ef372, 32'ha54ff53a,
		32'h510e527f, 32'h9b05688c, 32'h1f83d9ab, 32'h5be0cd19
	};

	// Published digest of "abc"
	localparam logic [255:0] ABC_DIGEST = {
		32'hba7816bf, 32'h8f01cfea, 32'h414140de, 32'h5dae2223,
		32'hb00361a3, 32'h96177a9c, 32'hb410ff61, 32'hf20015ad
	};

	localparam logic [31:0] KT [0:63] = '{
		32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5, 32'h3956c25b, 32'h59f111f1,
		32'h923f82a4, 32'hab1c5ed5, 32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
		32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174, 32'he49b69c1, 32'hefbe4786,
		32'h0fc19dc6, 32'h240ca1cc, 32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
		32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7, 32'hc6e00bf3, 32'hd5a79147,
		32'h06ca6351, 32'h14292967, 32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
		32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85, 32'ha2bfe8a1, 32'ha81a664b,
		32'hc24b8b70, 32'hc76c51a3, 32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
		32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5, 32'h391c0cb3, 32'h4ed8aa4a,
		32'h5b9cca4f, 32'h682e6ff3, 32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
		32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
	};

	logic         clk;
	logic         rst;
	logic [11:0]  awaddr;
	logic         awvalid;
	logic         awready;
	logic [31:0]  wdata;
	logic [3:0]   wstrb;
	logic         wvalid;
	logic         wready;
	logic [1:0]   bresp;
	logic         bvalid;
	logic         bready;
	logic [11:0]  araddr;
	logic         arvalid;
	logic         arready;
	logic [31:0]  rdata;
	logic [1:0]   rresp;
	logic         rvalid;
	logic         rready;

	integer       seed = 32'h8eaf_b038;
	int           value_errors = 0;
	int           proto_errors = 0;
	logic [255:0] ref_digest;
	logic [511:0] cur_blk;

	sha256_axil_top u_dut (.*);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial
	begin
		repeat (NUM_TESTS * 200 + 1000) @(posedge clk);
		$display("Watchdog expired before the tests finished");
		$display("Simulation failed");
		$finish;
	end

	// Write address and write data accepted in the same cycle
	assert property (@(posedge clk) disable iff (rst)
		awready == wready)
	else
	begin
		proto_errors++;
		$display("Write address and write data ready did not rise together");
	end

	// Responses held until the master takes them
	assert property (@(posedge clk) disable iff (rst)
		bvalid && !bready |=> bvalid && $stable(bresp))
	else
	begin
		proto_errors++;
		$display("Write response changed or dropped before bready");
	end

	assert property (@(posedge clk) disable iff (rst)
		rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
	else
	begin
		proto_errors++;
		$display("Read response changed or dropped before rready");
	end

	//////////////////////////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////////////////////////
	function automatic logic [31:0] rotate_right(input logic [31:0] x, input int n);
		return (x >> n) | (x << (32 - n));
	endfunction

	function automatic logic [255:0] sha_compress(input logic [255:0] hin,
			input logic [511:0] blk);
		logic [31:0]  ws [0:63];
		logic [31:0]  v [0:7];
		logic [31:0]  s0;
		logic [31:0]  s1;
		logic [31:0]  t1;
		logic [31:0]  t2;
		logic [255:0] hout;
		for (int i = 0; i < 16; i++)
			ws[i] = blk[511 - 32 * i -: 32];
		for (int i = 16; i < 64; i++)
		begin
			s0 = rotate_right(ws[i-15], 7) ^ rotate_right(ws[i-15], 18) ^ (ws[i-15] >> 3);
			s1 = rotate_right(ws[i-2], 17) ^ rotate_right(ws[i-2], 19) ^ (ws[i-2] >> 10);
			ws[i] = ws[i-16] + s0 + ws[i-7] + s1;
		end
		for (int i = 0; i < 8; i++)
			v[i] = hin[255 - 32 * i -: 32];
		for (int i = 0; i < 64; i++)
		begin
			s1 = rotate_right(v[4], 6) ^ rotate_right(v[4], 11) ^ rotate_right(v[4], 25);
			t1 = v[7] + s1 + ((v[4] & v[5]) ^ (~v[4] & v[6])) + KT[i] + ws[i];
			s0 = rotate_right(v[0], 2) ^ rotate_right(v[0], 13) ^ rotate_right(v[0], 22);
			t2 = s0 + ((v[0] & v[1]) ^ (v[0] & v[2]) ^ (v[1] & v[2]));
			for (int j = 7; j > 0; j--)
				v[j] = v[j-1];
			v[4] = v[4] + t1;
			v[0] = t1 + t2;
		end
		for (int i = 0; i < 8; i++)
			hout[255 - 32 * i -: 32] = hin[255 - 32 * i -: 32] + v[i];
		return hout;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Bus tasks
	//////////////////////////////////////////////////////////////////////
	task automatic check_value(input string name, input logic [255:0] exp,
			input logic [255:0] act);
		assert (act === exp)
		else
		begin
			$display("[FAIL] %s: expected %0h, actual %0h", name, exp, act);
			value_errors++;
		end
	endtask

	task automatic axil_write(input logic [11:0] addr, input logic [31:0] data,
			input logic [3:0] strb, output logic [1:0] resp);
		int delay;
		awaddr  <= addr;
		wdata   <= data;
		wstrb   <= strb;
		awvalid <= 1'b1;
		wvalid  <= 1'b1;
		do
			@(posedge clk);
		while (!awready);
		awvalid <= 1'b0;
		wvalid  <= 1'b0;
		// Random back-pressure on the response
		delay = $unsigned($random(seed)) % 3;
		repeat (delay) @(posedge clk);
		bready <= 1'b1;
		do
			@(posedge clk);
		while (!bvalid);
		resp = bresp;
		bready <= 1'b0;
	endtask

	task automatic axil_read(input logic [11:0] addr, output logic [31:0] data,
			output logic [1:0] resp);
		int delay;
		araddr  <= addr;
		arvalid <= 1'b1;
		do
			@(posedge clk);
		while (!arready);
		arvalid <= 1'b0;
		delay = $unsigned($random(seed)) % 3;
		repeat (delay) @(posedge clk);
		rready <= 1'b1;
		do
			@(posedge clk);
		while (!rvalid);
		data = rdata;
		resp = rresp;
		rready <= 1'b0;
	endtask

	task automatic fill_random_block();
		for (int i = 0; i < 16; i++)
			cur_blk[511 - 32 * i -: 32] = $random(seed);
	endtask

	task automatic write_block();
		logic [1:0] resp;
		for (int i = 0; i < 16; i++)
		begin
			axil_write(REG_BLOCK_BASE + 12'(4 * i), cur_blk[511 - 32 * i -: 32], 4'hf, resp);
			check_value("block bresp", OKAY, resp);
		end
	endtask

	task automatic wait_done();
		logic [31:0] status;
		logic [1:0]  resp;
		status = '0;
		while (!status[1])
			axil_read(REG_STATUS, status, resp);
	endtask

	task automatic read_digest(output logic [255:0] d);
		logic [31:0] data;
		logic [1:0]  resp;
		for (int i = 0; i < 8; i++)
		begin
			axil_read(REG_DIGEST_BASE + 12'(4 * i), data, resp);
			check_value("digest rresp", OKAY, resp);
			d[255 - 32 * i -: 32] = data;
		end
	endtask

	// Hash the block already in the registers, scribbling over it while busy
	task automatic hash_block(input string name, input logic chain, input int scribbles);
		logic [255:0] expected;
		logic [255:0] actual;
		logic [31:0]  data;
		logic [1:0]   resp;
		expected = sha_compress(chain ? ref_digest : IV, cur_blk);
		axil_write(REG_CTRL, {30'd0, chain, 1'b1}, 4'hf, resp);
		check_value({name, " ctrl bresp"}, OKAY, resp);
		if (scribbles > 0)
		begin
			for (int i = 0; i < scribbles; i++)
			begin
				data = $random(seed);
				axil_write(REG_BLOCK_BASE + 12'(4 * i), data, 4'hf, resp);
			end
			axil_read(REG_STATUS, data, resp);
			check_value({name, " busy"}, 1'b1, data[0]);
		end
		wait_done();
		read_digest(actual);
		check_value({name, " digest"}, expected, actual);
		ref_digest = expected;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////////////////////////
	initial
	begin
		logic [255:0] dut_digest;
		logic [255:0] expected;
		logic [31:0]  data;
		logic [31:0]  old_word;
		logic [31:0]  rnd;
		logic [7:0]   ch;
		logic [1:0]   resp;
		rst     = 1'b1;
		awaddr  = '0;
		awvalid = 1'b0;
		wdata   = '0;
		wstrb   = '0;
		wvalid  = 1'b0;
		bready  = 1'b0;
		araddr  = '0;
		arvalid = 1'b0;
		rready  = 1'b0;
		repeat (8) @(posedge clk);
		rst <= 1'b0;
		@(posedge clk);

		axil_read(REG_STATUS, data, resp);
		check_value("reset status", 32'd0, data);
		read_digest(dut_digest);
		check_value("reset digest", IV, dut_digest);
		ref_digest = IV;

		// Single block "abc"
		cur_blk = '0;
		cur_blk[511 -: 32] = 32'h61626380;
		cur_blk[31:0] = 32'h00000018;
		check_value("abc model", ABC_DIGEST, sha_compress(IV, cur_blk));
		write_block();
		hash_block("abc", 1'b0, 0);

		// 56-byte message over two blocks
		cur_blk = '0;
		for (int i = 0; i < 14; i++)
		begin
			ch = 8'h61 + i[7:0];
			cur_blk[511 - 32 * i -: 32] = {ch, ch + 8'd1, ch + 8'd2, ch + 8'd3};
		end
		cur_blk[63:32] = 32'h80000000;
		write_block();
		hash_block("two block first", 1'b0, 0);
		cur_blk = '0;
		cur_blk[31:0] = 32'h000001c0;
		write_block();
		hash_block("two block second", 1'b1, 0);

		for (int n = 0; n < 20; n++)
		begin
			fill_random_block();
			write_block();
			rnd = $random(seed);
			hash_block($sformatf("random %0d", n), rnd[0], 3);
		end

		// Second start lands while the core is busy
		fill_random_block();
		expected = sha_compress(IV, cur_blk);
		write_block();
		axil_write(REG_CTRL, 32'h1, 4'hf, resp);
		axil_write(REG_CTRL, 32'h3, 4'hf, resp);
		check_value("busy start bresp", OKAY, resp);
		wait_done();
		repeat (80) @(posedge clk);
		axil_read(REG_STATUS, data, resp);
		check_value("busy start status", 32'h2, data);
		read_digest(dut_digest);
		check_value("busy start digest", expected, dut_digest);
		ref_digest = expected;

		axil_write(12'h100, 32'hdeadbeef, 4'hf, resp);
		check_value("unmapped bresp", SLVERR, resp);
		axil_read(12'h100, data, resp);
		check_value("unmapped rresp", SLVERR, resp);
		check_value("unmapped rdata", 32'd0, data);
		axil_write(REG_STATUS, 32'hffffffff, 4'hf, resp);
		check_value("status write bresp", OKAY, resp);
		axil_read(REG_STATUS, data, resp);
		check_value("status after write", 32'h2, data);

		// Byte strobes on block word 5
		fill_random_block();
		write_block();
		data = $random(seed);
		old_word = cur_blk[351 -: 32];
		axil_write(REG_BLOCK_BASE + 12'h014, data, 4'b0101, resp);
		check_value("strobe bresp", OKAY, resp);
		cur_blk[351 -: 32] = (old_word & 32'hff00ff00) | (data & 32'h00ff00ff);
		axil_read(REG_BLOCK_BASE + 12'h014, data, resp);
		check_value("strobe readback", cur_blk[351 -: 32], data);
		hash_block("strobe", 1'b0, 0);

		$display("Errors: %0d value, %0d protocol", value_errors, proto_errors);
		if (value_errors == 0 && proto_errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== logic/sha256_axil_top.sv ====
`default_nettype none

module sha256_axil_top
	import sha256_pkg::*;
(
	input  wire         clk,
	input  wire         rst,
	input  wire [11:0]  awaddr,
	input  wire         awvalid,
	output logic        awready,
	input  wire [31:0]  wdata,
	input  wire [3:0]   wstrb,
	input  wire         wvalid,
	output logic        wready,
	output logic [1:0]  bresp,
	output logic        bvalid,
	input  wire         bready,
	input  wire [11:0]  araddr,
	input  wire         arvalid,
	output logic        arready,
	output logic [31:0] rdata,
	output logic [1:0]  rresp,
	output logic        rvalid,
	input  wire         rready
);

	// Register block to core
	hash_cmd_t cmd;
	block_t    block;
	digest_t   digest;
	logic      busy;
	logic      done;

	// Core to constant table and schedule
	round_t    round;
	logic      load;
	logic      step;
	word_t     k;
	word_t     w;

	axil_regs u_regs (.*);

	round_constants u_consts (.*);

	message_schedule u_sched (.*);

	compress_core u_core (.*);

endmodule

`default_nettype wire

// ==== logic/axil_regs.sv ====
`default_nettype none

module axil_regs
	import sha256_pkg::*;
(
	input  wire          clk,
	input  wire          rst,
	input  wire [11:0]   awaddr,
	input  wire          awvalid,
	output logic         awready,
	input  wire [31:0]   wdata,
	input  wire [3:0]    wstrb,
	input  wire          wvalid,
	output logic         wready,
	output logic [1:0]   bresp,
	output logic         bvalid,
	input  wire          bready,
	input  wire [11:0]   araddr,
	input  wire          arvalid,
	output logic         arready,
	output word_t        rdata,
	output logic [1:0]   rresp,
	output logic         rvalid,
	input  wire          rready,
	output hash_cmd_t    cmd,
	output block_t       block,
	input  wire          busy,
	input  wire          done,
	input  wire digest_t digest
);

	typedef struct packed {
		logic ctrl;
		logic status;
		logic blk;
		logic dig;
	} reg_sel_t;

	word_t [0:15] blk_q;
	word_t [0:7]  dig_words;
	reg_sel_t     wsel;
	reg_sel_t     rsel;
	logic         aw_w_ready;
	logic         wr_en;
	logic         rd_en;
	logic         start_ok;
	logic         done_sticky;
	word_t        rd_word;
	logic [1:0]   rd_resp;

	function automatic reg_sel_t decode(input logic [11:0] addr);
		reg_sel_t sel;
		sel.ctrl   = (addr[11:2] == REG_CTRL[11:2]);
		sel.status = (addr[11:2] == REG_STATUS[11:2]);
		sel.blk    = (addr[11:6] == REG_BLOCK_BASE[11:6]);
		sel.dig    = (addr[11:5] == REG_DIGEST_BASE[11:5]);
		return sel;
	endfunction

	assign wsel      = decode(awaddr);
	assign rsel      = decode(araddr);
	assign awready   = aw_w_ready;
	assign wready    = aw_w_ready;
	assign wr_en     = awvalid && wvalid && aw_w_ready;
	assign rd_en     = arvalid && arready;
	assign block     = blk_q;
	assign dig_words = digest;

	// Start is dropped while the core runs
	assign start_ok = wr_en && wsel.ctrl && wstrb[0] && wdata[0] && !busy;

	////////////////////////////////////////////////////////////////////
	// Write channels
	////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			aw_w_ready <= 1'b0;
			bvalid     <= 1'b0;
		end
		else
		begin
			// Address and data accepted together, one-cycle ready
			aw_w_ready <= awvalid && wvalid && !aw_w_ready && !bvalid;
			if (wr_en)
				bvalid <= 1'b1;
			else if (bready)
				bvalid <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (wr_en)
			bresp <= (wsel != '0) ? RESP_OKAY : RESP_SLVERR;
	end

	// Block words with byte strobes
	always_ff @(posedge clk)
	begin
		if (wr_en && wsel.blk)
		begin
			for (int i = 0; i < 4; i++)
			begin
				if (wstrb[i])
					blk_q[awaddr[5:2]][8*i +: 8] <= wdata[8*i +: 8];
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			cmd         <= '0;
			done_sticky <= 1'b0;
		end
		else
		begin
			cmd.start <= start_ok;
			if (start_ok)
				cmd.chain <= wdata[1];
			if (done)
				done_sticky <= 1'b1;
			else if (cmd.start)
				done_sticky <= 1'b0;
		end
	end

	////////////////////////////////////////////////////////////////////
	// Read channels
	////////////////////////////////////////////////////////////////////
	always_comb
	begin
		rd_word = '0;
		rd_resp = RESP_OKAY;
		if (rsel.ctrl)
			rd_word = {30'd0, cmd.chain, 1'b0};
		else if (rsel.status)
			rd_word = {30'd0, done_sticky, busy};
		else if (rsel.blk)
			rd_word = blk_q[araddr[5:2]];
		else if (rsel.dig)
			rd_word = dig_words[araddr[4:2]];
		else
			rd_resp = RESP_SLVERR;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			arready <= 1'b0;
			rvalid  <= 1'b0;
		end
		else
		begin
			arready <= arvalid && !arready && !rvalid;
			if (rd_en)
				rvalid <= 1'b1;
			else if (rready)
				rvalid <= 1'b0;
		end
	end

	// Read data held with rvalid until rready
	always_ff @(posedge clk)
	begin
		if (rd_en)
		begin
			rdata <= rd_word;
			rresp <= rd_resp;
		end
	end

endmodule

`default_nettype wire

// ==== sha256/compress_core.sv ====
`default_nettype none

module compress_core
	import sha256_pkg::*;
(
	input  wire            clk,
	input  wire            rst,
	input  wire hash_cmd_t cmd,
	input  wire word_t     k,
	input  wire word_t     w,
	output round_t         round,
	output logic           load,
	output logic           step,
	output logic           busy,
	output logic           done,
	output digest_t        digest
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_LOAD,
		ST_ROUNDS,
		ST_FINISH
	} state_t;

	state_t  state;
	round_t  cnt;
	digest_t digest_q;
	digest_t start_vars;
	word_t   a, b, c, d, e, f, g, h;
	word_t   t1;
	word_t   t2;

	function automatic word_t big_sigma0(input word_t x);
		return rotr(x, 2) ^ rotr(x, 13) ^ rotr(x, 22);
	endfunction

	function automatic word_t big_sigma1(input word_t x);
		return rotr(x, 6) ^ rotr(x, 11) ^ rotr(x, 25);
	endfunction

	function automatic word_t ch(input word_t x, input word_t y, input word_t z);
		return (x & y) ^ (~x & z);
	endfunction

	function automatic word_t maj(input word_t x, input word_t y, input word_t z);
		return (x & y) ^ (x & z) ^ (y & z);
	endfunction

	////////////////////////////////////////////////////////////////////
	// Control
	////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state    <= ST_IDLE;
			cnt      <= '0;
			digest_q <= INIT_DIGEST;
		end
		else
		begin
			case (state)
				ST_IDLE:
				begin
					if (cmd.start)
					begin
						state <= ST_LOAD;
						if (!cmd.chain)
							digest_q <= INIT_DIGEST;
					end
				end
				ST_LOAD:
				begin
					state <= ST_ROUNDS;
					cnt   <= '0;
				end
				ST_ROUNDS:
				begin
					cnt <= cnt + 6'd1;
					if ({1'b0, cnt} == NUM_ROUNDS - 7'd1)
						state <= ST_FINISH;
				end
				ST_FINISH:
				begin
					digest_q.h0 <= digest_q.h0 + a;
					digest_q.h1 <= digest_q.h1 + b;
					digest_q.h2 <= digest_q.h2 + c;
					digest_q.h3 <= digest_q.h3 + d;
					digest_q.h4 <= digest_q.h4 + e;
					digest_q.h5 <= digest_q.h5 + f;
					digest_q.h6 <= digest_q.h6 + g;
					digest_q.h7 <= digest_q.h7 + h;
					state       <= ST_IDLE;
				end
				default:
					state <= ST_IDLE;
			endcase
		end
	end

	////////////////////////////////////////////////////////////////////
	// Round datapath
	////////////////////////////////////////////////////////////////////
	assign start_vars = cmd.chain ? digest_q : INIT_DIGEST;
	assign t1 = h + big_sigma1(e) + ch(e, f, g) + k + w;
	assign t2 = big_sigma0(a) + maj(a, b, c);

	always_ff @(posedge clk)
	begin
		if (state == ST_IDLE && cmd.start)
		begin
			a <= start_vars.h0;
			b <= start_vars.h1;
			c <= start_vars.h2;
			d <= start_vars.h3;
			e <= start_vars.h4;
			f <= start_vars.h5;
			g <= start_vars.h6;
			h <= start_vars.h7;
		end
		else if (state == ST_ROUNDS)
		begin
			a <= t1 + t2;
			b <= a;
			c <= b;
			d <= c;
			e <= d + t1;
			f <= e;
			g <= f;
			h <= g;
		end
	end

	// Index one ahead, the constant table has a cycle of latency
	assign round  = (state == ST_ROUNDS) ? cnt + 6'd1 : '0;
	assign load   = (state == ST_LOAD);
	assign step   = (state == ST_ROUNDS);
	assign busy   = (state != ST_IDLE);
	assign done   = (state == ST_FINISH);
	assign digest = digest_q;

endmodule

`default_nettype wire

// ==== sha256/message_schedule.sv ====
`default_nettype none

module message_schedule
	import sha256_pkg::*;
(
	input  wire         clk,
	input  wire         load,
	input  wire         step,
	input  wire block_t block,
	output word_t       w
);

	// Window of the last sixteen schedule words, oldest at index 0
	word_t [0:15] win;
	word_t        w_new;

	function automatic word_t small_sigma0(input word_t x);
		return rotr(x, 7) ^ rotr(x, 18) ^ (x >> 3);
	endfunction

	function automatic word_t small_sigma1(input word_t x);
		return rotr(x, 17) ^ rotr(x, 19) ^ (x >> 10);
	endfunction

	// Expansion from the words 2, 7, 15 and 16 rounds back
	assign w_new = small_sigma1(win[14]) + win[9] + small_sigma0(win[1]) + win[0];

	always_ff @(posedge clk)
	begin
		if (load)
		begin
			// Snapshot, so the block registers are free during a hash
			win <= block;
		end
		else if (step)
		begin
			win <= {win[1:15], w_new};
		end
	end

	assign w = win[0];

endmodule

`default_nettype wire

// ==== sha256/round_constants.sv ====
`default_nettype none

module round_constants
	import sha256_pkg::*;
(
	input  wire         clk,
	input  wire round_t round,
	output word_t       k
);

	// Fractional parts of the cube roots of the first 64 primes
	word_t rom [NUM_ROUNDS];

	// Synchronous read, k belongs to the index of the previous edge
	always_ff @(posedge clk)
	begin
		k <= rom[round];
	end

	initial
	begin
		rom[0]  = 32'h428a2f98;
		rom[1]  = 32'h71374491;
		rom[2]  = 32'hb5c0fbcf;
		rom[3]  = 32'he9b5dba5;
		rom[4]  = 32'h3956c25b;
		rom[5]  = 32'h59f111f1;
		rom[6]  = 32'h923f82a4;
		rom[7]  = 32'hab1c5ed5;
		rom[8]  = 32'hd807aa98;
		rom[9]  = 32'h12835b01;
		rom[10] = 32'h243185be;
		rom[11] = 32'h550c7dc3;
		rom[12] = 32'h72be5d74;
		rom[13] = 32'h80deb1fe;
		rom[14] = 32'h9bdc06a7;
		rom[15] = 32'hc19bf174;
		rom[16] = 32'he49b69c1;
		rom[17] = 32'hefbe4786;
		rom[18] = 32'h0fc19dc6;
		rom[19] = 32'h240ca1cc;
		rom[20] = 32'h2de92c6f;
		rom[21] = 32'h4a7484aa;
		rom[22] = 32'h5cb0a9dc;
		rom[23] = 32'h76f988da;
		rom[24] = 32'h983e5152;
		rom[25] = 32'ha831c66d;
		rom[26] = 32'hb00327c8;
		rom[27] = 32'hbf597fc7;
		rom[28] = 32'hc6e00bf3;
		rom[29] = 32'hd5a79147;
		rom[30] = 32'h06ca6351;
		rom[31] = 32'h14292967;
		rom[32] = 32'h27b70a85;
		rom[33] = 32'h2e1b2138;
		rom[34] = 32'h4d2c6dfc;
		rom[35] = 32'h53380d13;
		rom[36] = 32'h650a7354;
		rom[37] = 32'h766a0abb;
		rom[38] = 32'h81c2c92e;
		rom[39] = 32'h92722c85;
		rom[40] = 32'ha2bfe8a1;
		rom[41] = 32'ha81a664b;
		rom[42] = 32'hc24b8b70;
		rom[43] = 32'hc76c51a3;
		rom[44] = 32'hd192e819;
		rom[45] = 32'hd6990624;
		rom[46] = 32'hf40e3585;
		rom[47] = 32'h106aa070;
		rom[48] = 32'h19a4c116;
		rom[49] = 32'h1e376c08;
		rom[50] = 32'h2748774c;
		rom[51] = 32'h34b0bcb5;
		rom[52] = 32'h391c0cb3;
		rom[53] = 32'h4ed8aa4a;
		rom[54] = 32'h5b9cca4f;
		rom[55] = 32'h682e6ff3;
		rom[56] = 32'h748f82ee;
		rom[57] = 32'h78a5636f;
		rom[58] = 32'h84c87814;
		rom[59] = 32'h8cc70208;
		rom[60] = 32'h90befffa;
		rom[61] = 32'ha4506ceb;
		rom[62] = 32'hbef9a3f7;
		rom[63] = 32'hc67178f2;
	end

endmodule

`default_nettype wire

// ==== common/sha256_pkg.sv ====
`default_nettype none

package sha256_pkg;

	// One 32-bit data word
	typedef logic [31:0] word_t;

	// Round index, 0 to 63
	typedef logic [5:0] round_t;

	// Padded message block, word 0 in the top bits
	typedef struct packed {
		word_t w0;
		word_t w1;
		word_t w2;
		word_t w3;
		word_t w4;
		word_t w5;
		word_t w6;
		word_t w7;
		word_t w8;
		word_t w9;
		word_t w10;
		word_t w11;
		word_t w12;
		word_t w13;
		word_t w14;
		word_t w15;
	} block_t;

	// Chaining value, h0 in the top bits
	typedef struct packed {
		word_t h0;
		word_t h1;
		word_t h2;
		word_t h3;
		word_t h4;
		word_t h5;
		word_t h6;
		word_t h7;
	} digest_t;

	// Command from the register block to the core
	typedef struct packed {
		logic start;
		logic chain;
	} hash_cmd_t;

	localparam digest_t INIT_DIGEST = '{
		h0: 32'h6a09e667, h1: 32'hbb67ae85, h2: 32'h3c6ef372, h3: 32'ha54ff53a,
		h4: 32'h510e527f, h5: 32'h9b05688c, h6: 32'h1f83d9ab, h7: 32'h5be0cd19
	};

	localparam logic [6:0] NUM_ROUNDS = 7'd64;

	////////////////////////////////////////////////////////////////////
	// Register map
	////////////////////////////////////////////////////////////////////
	localparam logic [11:0] REG_CTRL        = 12'h000;
	localparam logic [11:0] REG_STATUS      = 12'h004;
	localparam logic [11:0] REG_BLOCK_BASE  = 12'h040;
	localparam logic [11:0] REG_DIGEST_BASE = 12'h080;

	// AXI response codes
	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	// Rotate right by a constant amount
	function automatic word_t rotr(input word_t x, input int unsigned n);
		return (x >> n) | (x << (32 - n));
	endfunction

endpackage

`default_nettype wire
